// ==== hw/lfps_pkg.sv ====
// lfps link front end types
`default_nettype none

package lfps_pkg;

	// cycle counts for burst widths, spacings and timeouts
	typedef logic [15:0] lfps_count_t;

	//////////////////////////////////////////////////
	// received burst kinds
	//////////////////////////////////////////////////
	typedef enum logic [2:0] {
		kind_poll      = 3'd0,	// polling.lfps
		kind_ping      = 3'd1,	// ping.lfps
		kind_u1_exit   = 3'd2,
		kind_u2lb_exit = 3'd3,	// u2 or loopback exit
		kind_u3_wakeup = 3'd4
	} lfps_kind_t;

	//////////////////////////////////////////////////
	// link trainer states
	//////////////////////////////////////////////////
	typedef enum logic [2:0] {
		lt_reset         = 3'd0,
		lt_detect_active = 3'd1,	// far-end detect requested
		lt_detect_wait   = 3'd2,	// phy busy with detection
		lt_detect_quiet  = 3'd3,
		lt_polling_lfps  = 3'd4,
		lt_polling_done  = 3'd5,	// terminal
		lt_ss_disabled   = 3'd6	// terminal
	} ltssm_state_t;

	// event queue entries
	localparam int FIFO_DEPTH = 4;

endpackage

`default_nettype wire

// ==== hw/lfps_event_if.sv ====
// lfps event queue interface
`timescale 1ns/1ns
`default_nettype none

interface lfps_event_if import lfps_pkg::*; ();

	logic       push;		// one-cycle strobe
	lfps_kind_t push_kind;
	logic       pop;		// only while not empty
	lfps_kind_t head_kind;	// valid while not empty
	logic       empty;

	// classifier side
	modport producer (output push, output push_kind);

	// queue storage
	modport buffer (input push, input push_kind, input pop,
		output head_kind, output empty);

	// trainer side
	modport consumer (input head_kind, input empty, output pop);

endinterface

`default_nettype wire

// ==== hw/lfps_tx_burst.sv ====
// lfps burst transmitter
`timescale 1ns/1ns
`default_nettype none

module lfps_tx_burst import lfps_pkg::*; #(
	parameter lfps_count_t TX_POLL_WIDTH  = 16'd15,
	parameter lfps_count_t TX_POLL_REPEAT = 16'd60
) (
	input  logic slow_clk,
	input  logic lfps_send_reset_local,
	input  logic port_rx_elecidle,
	input  logic send_poll,
	output logic send_ack,
	output logic port_tx_elecidle
);

	typedef enum logic [1:0] {tx_idle, tx_send, tx_gap} tx_state_t;

	tx_state_t   tx_state;
	logic        elecidle_s1, elecidle_s2;
	lfps_count_t width_cnt;		// burst cycles left
	lfps_count_t repeat_cnt;	// cycles left in repeat interval

	always_ff @(posedge slow_clk) begin
		if (lfps_send_reset_local) begin
			{elecidle_s2, elecidle_s1} <= 2'b11;
			tx_state         <= tx_idle;
			width_cnt        <= '0;
			repeat_cnt       <= '0;
			port_tx_elecidle <= 1'b1;
			send_ack         <= 1'b0;
		end else begin
			{elecidle_s2, elecidle_s1} <= {elecidle_s1, port_rx_elecidle};
			send_ack <= 1'b0;
			case (tx_state)
			tx_idle: begin
				// only start while the line is quiet
				if (send_poll && elecidle_s2) begin
					width_cnt        <= TX_POLL_WIDTH;
					repeat_cnt       <= TX_POLL_REPEAT - 1'b1;
					port_tx_elecidle <= 1'b0;
					tx_state         <= tx_send;
				end
			end
			tx_send: begin
				width_cnt  <= width_cnt - 1'b1;
				repeat_cnt <= repeat_cnt - 1'b1;
				if (width_cnt == 16'd1) begin	// burst over
					port_tx_elecidle <= 1'b1;
					tx_state         <= tx_gap;
				end
			end
			tx_gap: begin
				repeat_cnt <= repeat_cnt - 1'b1;
				if (repeat_cnt == 16'd1) begin
					send_ack <= 1'b1;	// interval done, next start may follow
					tx_state <= tx_idle;
				end
			end
			default: tx_state <= tx_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/lfps_rx_classifier.sv ====
// lfps burst receiver and classifier
`timescale 1ns/1ns
`default_nettype none

module lfps_rx_classifier import lfps_pkg::*; #(
	parameter lfps_count_t POLL_MIN       = 16'd10,
	parameter lfps_count_t POLL_MAX       = 16'd20,
	parameter lfps_count_t PING_MIN       = 16'd2,
	parameter lfps_count_t PING_MAX       = 16'd5,
	parameter lfps_count_t U1_MIN         = 16'd21,
	parameter lfps_count_t U1_MAX         = 16'd40,
	parameter lfps_count_t U2LB_MIN       = 16'd41,
	parameter lfps_count_t U2LB_MAX       = 16'd80,
	parameter lfps_count_t U3_MIN         = 16'd81,
	parameter lfps_count_t U3_MAX         = 16'd160,
	parameter lfps_count_t BURST_POLL_MIN = 16'd50,
	parameter lfps_count_t BURST_POLL_MAX = 16'd150,
	parameter lfps_count_t BURST_PING_MIN = 16'd30,
	parameter lfps_count_t BURST_PING_MAX = 16'd300
) (
	input  logic           slow_clk,
	input  logic           lfps_send_reset_local,
	input  logic           port_rx_elecidle,
	input  logic           port_rx_valid,
	output logic           recv_poll,
	output logic           recv_ping,
	output logic           recv_u1,
	output logic           recv_u2lb,
	output logic           recv_u3,
	lfps_event_if.producer ev
);

	typedef enum logic {rx_idle, rx_burst} rx_state_t;

	rx_state_t   rx_state;
	logic        elecidle_s1, elecidle_s2;
	logic        valid_s1, valid_s2;
	lfps_count_t width_cnt;		// cycles since burst start
	lfps_count_t space_cnt;		// cycles since last burst end
	logic        poll_seen, ping_seen;
	logic        poll_next, ping_next;
	logic        burst_end;
	logic        hit;
	lfps_kind_t  hit_kind;

	// min inclusive, max exclusive
	function automatic logic in_win(input lfps_count_t v, input lfps_count_t lo,
		input lfps_count_t hi);
		return (v >= lo) && (v < hi);
	endfunction

	assign burst_end = (rx_state == rx_burst) && elecidle_s2;

	//////////////////////////////////////////////////
	// classify the finished burst
	//////////////////////////////////////////////////
	always_comb begin
		hit       = 1'b0;
		hit_kind  = kind_poll;
		poll_next = 1'b0;	// any other burst clears both
		ping_next = 1'b0;
		if (in_win(width_cnt, POLL_MIN, POLL_MAX)) begin
			poll_next = 1'b1;
			hit       = poll_seen && in_win(space_cnt, BURST_POLL_MIN, BURST_POLL_MAX);
		end else if (in_win(width_cnt, PING_MIN, PING_MAX)) begin
			ping_next = 1'b1;
			hit       = ping_seen && in_win(space_cnt, BURST_PING_MIN, BURST_PING_MAX);
			hit_kind  = kind_ping;
		end else if (in_win(width_cnt, U1_MIN, U1_MAX)) begin
			hit      = 1'b1;
			hit_kind = kind_u1_exit;
		end else if (in_win(width_cnt, U2LB_MIN, U2LB_MAX)) begin
			hit      = 1'b1;
			hit_kind = kind_u2lb_exit;
		end else if (in_win(width_cnt, U3_MIN, U3_MAX)) begin
			hit      = 1'b1;
			hit_kind = kind_u3_wakeup;
		end
	end

	always_ff @(posedge slow_clk) begin
		if (lfps_send_reset_local) begin
			{elecidle_s2, elecidle_s1} <= 2'b11;
			{valid_s2, valid_s1}       <= 2'b00;
			rx_state  <= rx_idle;
			width_cnt <= '0;
			space_cnt <= '0;
			poll_seen <= 1'b0;
			ping_seen <= 1'b0;
			ev.push   <= 1'b0;
			{recv_poll, recv_ping, recv_u1, recv_u2lb, recv_u3} <= '0;
		end else begin
			{elecidle_s2, elecidle_s1} <= {elecidle_s1, port_rx_elecidle};
			{valid_s2, valid_s1}       <= {valid_s1, port_rx_valid};
			if (space_cnt != '1)
				space_cnt <= space_cnt + 1'b1;	// saturates on long silence
			if (rx_state == rx_idle) begin
				if (!elecidle_s2 && !valid_s2) begin	// burst start
					width_cnt <= 16'd1;
					rx_state  <= rx_burst;
				end
			end else if (elecidle_s2) begin
				rx_state  <= rx_idle;
				space_cnt <= 16'd1;	// end to end spacing
				poll_seen <= poll_next;
				ping_seen <= ping_next;
			end else if (width_cnt != '1) begin
				width_cnt <= width_cnt + 1'b1;
			end
			ev.push   <= burst_end && hit;
			recv_poll <= burst_end && hit && (hit_kind == kind_poll);
			recv_ping <= burst_end && hit && (hit_kind == kind_ping);
			recv_u1   <= burst_end && hit && (hit_kind == kind_u1_exit);
			recv_u2lb <= burst_end && hit && (hit_kind == kind_u2lb_exit);
			recv_u3   <= burst_end && hit && (hit_kind == kind_u3_wakeup);
		end
	end

	always_ff @(posedge slow_clk) begin
		if (burst_end)
			ev.push_kind <= hit_kind;
	end

endmodule

`default_nettype wire

// ==== hw/lfps_event_fifo.sv ====
// lfps event queue
`timescale 1ns/1ns
`default_nettype none

module lfps_event_fifo import lfps_pkg::*; (
	input  logic         slow_clk,
	input  logic         lfps_send_reset_local,
	lfps_event_if.buffer ev
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	lfps_kind_t       mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push, do_pop;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign do_push      = ev.push && (count != CNT_W'(FIFO_DEPTH));	// full drops
	assign do_pop       = ev.pop && (count != '0);
	assign ev.empty     = (count == '0);
	assign ev.head_kind = mem[rd_ptr];

	always_ff @(posedge slow_clk) begin
		if (lfps_send_reset_local) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	// storage
	always_ff @(posedge slow_clk) begin
		if (do_push)
			mem[wr_ptr] <= ev.push_kind;
	end

endmodule

`default_nettype wire

// ==== hw/lfps_link_trainer.sv ====
// link trainer, rx detect and polling.lfps
`timescale 1ns/1ns
`default_nettype none

module lfps_link_trainer import lfps_pkg::*; #(
	parameter lfps_count_t T_DETECT_QUIET = 16'd20,
	parameter lfps_count_t T_POLLING_LFPS = 16'd4000,
	parameter lfps_count_t TX_POLL_WIDTH  = 16'd15,
	parameter lfps_count_t TX_POLL_REPEAT = 16'd60
) (
	input  logic           slow_clk,
	input  logic           lfps_send_reset_local,
	input  logic           vbus_present,
	input  logic           partner_looking,
	input  logic           partner_detected,
	output logic           partner_detect,
	output ltssm_state_t   ltssm_state,
	input  logic           port_rx_elecidle,
	output logic           port_tx_elecidle,
	lfps_event_if.consumer ev
);

	ltssm_state_t state;
	logic         vbus_s1, vbus_s2;
	lfps_count_t  dc;					// delay count
	logic [3:0]   detect_fails;
	logic [4:0]   lfps_sent, lfps_rcvd, sent_after_rcvd;
	logic         send_poll, send_ack;
	logic         poll_popped;
	logic         polling_met;

	assign ltssm_state    = state;
	assign partner_detect = (state == lt_detect_active);
	assign send_poll      = (state == lt_polling_lfps);
	assign ev.pop         = !ev.empty;	// drain every entry
	assign poll_popped    = ev.pop && (ev.head_kind == kind_poll);
	assign polling_met    = (lfps_sent >= 5'd16) && (lfps_rcvd >= 5'd2)
		&& (sent_after_rcvd >= 5'd4);

	always_ff @(posedge slow_clk) begin
		if (lfps_send_reset_local)
			{vbus_s2, vbus_s1} <= 2'b00;
		else
			{vbus_s2, vbus_s1} <= {vbus_s1, vbus_present};
	end

	//////////////////////////////////////////////////
	// trainer fsm
	//////////////////////////////////////////////////
	always_ff @(posedge slow_clk) begin
		if (lfps_send_reset_local || !vbus_s2) begin
			state           <= lt_reset;
			dc              <= '0;
			detect_fails    <= '0;
			lfps_sent       <= '0;
			lfps_rcvd       <= '0;
			sent_after_rcvd <= '0;
		end else begin
			case (state)
			lt_reset: begin
				detect_fails <= '0;
				state        <= lt_detect_active;
			end
			lt_detect_active: begin
				if (partner_looking)
					state <= lt_detect_wait;
			end
			lt_detect_wait: begin
				if (!partner_looking) begin	// detection finished
					dc <= '0;
					if (partner_detected) begin
						lfps_sent       <= '0;
						lfps_rcvd       <= '0;
						sent_after_rcvd <= '0;
						state           <= lt_polling_lfps;
					end else begin
						detect_fails <= detect_fails + 1'b1;
						state <= (detect_fails == 4'd7) ? lt_ss_disabled : lt_detect_quiet;
					end
				end
			end
			lt_detect_quiet: begin
				dc <= dc + 1'b1;
				if (dc == T_DETECT_QUIET - 1'b1)
					state <= lt_detect_active;
			end
			lt_polling_lfps: begin
				dc <= dc + 1'b1;
				if (send_ack && lfps_sent != '1)
					lfps_sent <= lfps_sent + 1'b1;
				if (poll_popped && lfps_rcvd != '1)
					lfps_rcvd <= lfps_rcvd + 1'b1;
				if (send_ack && lfps_rcvd != '0 && sent_after_rcvd != '1)
					sent_after_rcvd <= sent_after_rcvd + 1'b1;
				if (polling_met)
					state <= lt_polling_done;
				else if (dc == T_POLLING_LFPS - 1'b1)
					state <= lt_ss_disabled;	// timed out
			end
			lt_polling_done, lt_ss_disabled: state <= state;
			default: state <= lt_reset;
			endcase
		end
	end

	lfps_tx_burst #(
		.TX_POLL_WIDTH  (TX_POLL_WIDTH),
		.TX_POLL_REPEAT (TX_POLL_REPEAT)
	) u_lfps_tx_burst (
		.slow_clk              (slow_clk),
		.lfps_send_reset_local (lfps_send_reset_local),
		.port_rx_elecidle      (port_rx_elecidle),
		.send_poll             (send_poll),
		.send_ack              (send_ack),
		.port_tx_elecidle      (port_tx_elecidle)
	);

endmodule

`default_nettype wire

// ==== hw/usb3_lfps_top.sv ====
// usb3 lfps front end top
`timescale 1ns/1ns
`default_nettype none

module usb3_lfps_top import lfps_pkg::*; (
	input  logic       slow_clk,
	input  logic       lfps_send_reset_local,
	input  logic       vbus_present,
	input  logic       port_rx_elecidle,
	input  logic       port_rx_valid,
	input  logic       partner_looking,
	input  logic       partner_detected,
	output logic       port_tx_elecidle,
	output logic       partner_detect,
	output logic       lfps_recv_poll_u1,
	output logic       lfps_recv_ping,
	output logic       lfps_recv_u2lb,
	output logic       lfps_recv_u3,
	output logic [2:0] ltssm_state
);

	// simulation scale timing, in slow_clk cycles
	localparam lfps_count_t POLL_MIN       = 16'd10;
	localparam lfps_count_t POLL_MAX       = 16'd20;
	localparam lfps_count_t PING_MIN       = 16'd2;
	localparam lfps_count_t PING_MAX       = 16'd5;
	localparam lfps_count_t U1_MIN         = 16'd21;
	localparam lfps_count_t U1_MAX         = 16'd40;
	localparam lfps_count_t U2LB_MIN       = 16'd41;
	localparam lfps_count_t U2LB_MAX       = 16'd80;
	localparam lfps_count_t U3_MIN         = 16'd81;
	localparam lfps_count_t U3_MAX         = 16'd160;
	localparam lfps_count_t BURST_POLL_MIN = 16'd50;
	localparam lfps_count_t BURST_POLL_MAX = 16'd150;
	localparam lfps_count_t BURST_PING_MIN = 16'd30;
	localparam lfps_count_t BURST_PING_MAX = 16'd300;
	localparam lfps_count_t TX_POLL_WIDTH  = 16'd15;
	localparam lfps_count_t TX_POLL_REPEAT = 16'd60;
	localparam lfps_count_t T_DETECT_QUIET = 16'd20;
	localparam lfps_count_t T_POLLING_LFPS = 16'd4000;

	logic recv_poll, recv_u1;

	lfps_event_if u_ev ();

	assign lfps_recv_poll_u1 = recv_poll | recv_u1;	// shared pulse for both

	lfps_rx_classifier #(
		.POLL_MIN (POLL_MIN), .POLL_MAX (POLL_MAX),
		.PING_MIN (PING_MIN), .PING_MAX (PING_MAX),
		.U1_MIN (U1_MIN), .U1_MAX (U1_MAX),
		.U2LB_MIN (U2LB_MIN), .U2LB_MAX (U2LB_MAX),
		.U3_MIN (U3_MIN), .U3_MAX (U3_MAX),
		.BURST_POLL_MIN (BURST_POLL_MIN), .BURST_POLL_MAX (BURST_POLL_MAX),
		.BURST_PING_MIN (BURST_PING_MIN), .BURST_PING_MAX (BURST_PING_MAX)
	) u_lfps_rx_classifier (
		.slow_clk              (slow_clk),
		.lfps_send_reset_local (lfps_send_reset_local),
		.port_rx_elecidle      (port_rx_elecidle),
		.port_rx_valid         (port_rx_valid),
		.recv_poll             (recv_poll),
		.recv_ping             (lfps_recv_ping),
		.recv_u1               (recv_u1),
		.recv_u2lb             (lfps_recv_u2lb),
		.recv_u3               (lfps_recv_u3),
		.ev                    (u_ev.producer)
	);

	lfps_event_fifo u_lfps_event_fifo (
		.slow_clk              (slow_clk),
		.lfps_send_reset_local (lfps_send_reset_local),
		.ev                    (u_ev.buffer)
	);

	lfps_link_trainer #(
		.T_DETECT_QUIET (T_DETECT_QUIET),
		.T_POLLING_LFPS (T_POLLING_LFPS),
		.TX_POLL_WIDTH  (TX_POLL_WIDTH),
		.TX_POLL_REPEAT (TX_POLL_REPEAT)
	) u_lfps_link_trainer (
		.slow_clk              (slow_clk),
		.lfps_send_reset_local (lfps_send_reset_local),
		.vbus_present          (vbus_present),
		.partner_looking       (partner_looking),
		.partner_detected      (partner_detected),
		.partner_detect        (partner_detect),
		.ltssm_state           (ltssm_state),
		.port_rx_elecidle      (port_rx_elecidle),
		.port_tx_elecidle      (port_tx_elecidle),
		.ev                    (u_ev.consumer)
	);

endmodule

`default_nettype wire

// ==== testbench/lfps_assertions.sv ====
// lfps queue and transmitter assertions
`timescale 1ns/1ns
`default_nettype none

module lfps_assertions import lfps_pkg::*; (
	input logic       slow_clk,
	input logic       lfps_send_reset_local,
	input logic [2:0] fifo_count,
	input logic       pop,
	input logic       empty,
	input logic       send_ack,
	input logic       tx_elecidle
);

	int fail_count = 0;

	// queue occupancy stays within its storage
	a_count_bound: assert property (@(posedge slow_clk) disable iff (lfps_send_reset_local)
		fifo_count <= FIFO_DEPTH)
		else begin
			fail_count++;
			$error("event queue count above its depth");
		end

	a_pop_not_empty: assert property (@(posedge slow_clk) disable iff (lfps_send_reset_local)
		pop |-> !empty)
		else begin
			fail_count++;
			$error("event queue popped while empty");
		end

	// ack belongs to the quiet part of the repeat interval
	a_ack_idle: assert property (@(posedge slow_clk) disable iff (lfps_send_reset_local)
		send_ack |-> tx_elecidle)
		else begin
			fail_count++;
			$error("send_ack high during a transmitted burst");
		end

endmodule

`default_nettype wire

// ==== testbench/tb_usb3_lfps.sv ====
// usb3 lfps front end testbench
`timescale 1ns/1ns
`default_nettype none

module tb_usb3_lfps import lfps_pkg::*; ();

	typedef struct {
		string      name;
		int         width_lo;
		int         width_hi;
		int         gap;		// idle cycles after the burst
		logic [3:0] expected;	// {u3, u2lb, ping, poll_u1}
	} burst_row_t;

	logic       slow_clk;
	logic       lfps_send_reset_local;
	logic       vbus_present;
	logic       port_rx_elecidle;
	logic       port_rx_valid;
	logic       partner_looking;
	logic       partner_detected;
	logic       port_tx_elecidle;
	logic       partner_detect;
	logic       lfps_recv_poll_u1;
	logic       lfps_recv_ping;
	logic       lfps_recv_u2lb;
	logic       lfps_recv_u3;
	logic [2:0] ltssm_state;
	logic [3:0] pulses_now;
	burst_row_t rows [9];
	int         errors;
	int         checks;

	assign pulses_now = {lfps_recv_u3, lfps_recv_u2lb, lfps_recv_ping, lfps_recv_poll_u1};

	usb3_lfps_top u_usb3_lfps_top (
		.slow_clk              (slow_clk),
		.lfps_send_reset_local (lfps_send_reset_local),
		.vbus_present          (vbus_present),
		.port_rx_elecidle      (port_rx_elecidle),
		.port_rx_valid         (port_rx_valid),
		.partner_looking       (partner_looking),
		.partner_detected      (partner_detected),
		.port_tx_elecidle      (port_tx_elecidle),
		.partner_detect        (partner_detect),
		.lfps_recv_poll_u1     (lfps_recv_poll_u1),
		.lfps_recv_ping        (lfps_recv_ping),
		.lfps_recv_u2lb        (lfps_recv_u2lb),
		.lfps_recv_u3          (lfps_recv_u3),
		.ltssm_state           (ltssm_state)
	);

	bind lfps_event_fifo lfps_assertions u_fifo_assertions (
		.slow_clk              (slow_clk),
		.lfps_send_reset_local (lfps_send_reset_local),
		.fifo_count            (count),
		.pop                   (ev.pop),
		.empty                 (ev.empty),
		.send_ack              (1'b0),
		.tx_elecidle           (1'b1)
	);

	bind lfps_tx_burst lfps_assertions u_tx_assertions (
		.slow_clk              (slow_clk),
		.lfps_send_reset_local (lfps_send_reset_local),
		.fifo_count            (3'd0),
		.pop                   (1'b0),
		.empty                 (1'b1),
		.send_ack              (send_ack),
		.tx_elecidle           (port_tx_elecidle)
	);

	always #4 slow_clk = ~slow_clk;	// 8 ns period

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////
	task automatic next_cycle();
		@(posedge slow_clk);
		#1;	// drive and sample point
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		checks++;
		if (expected != actual) begin
			errors++;
			$display("error: %s expected %0d actual %0d", name, expected, actual);
		end
	endtask

	function automatic int pick_width(input int lo, input int hi);
		return lo + int'($urandom % (hi - lo + 1));
	endfunction

	task automatic apply_reset();
		lfps_send_reset_local = 1'b1;
		repeat (2) next_cycle();
		lfps_send_reset_local = 1'b0;
	endtask

	task automatic wait_state(input ltssm_state_t target, input int limit, output int cycles);
		cycles = 0;
		while (ltssm_state != target && cycles < limit) begin
			next_cycle();
			cycles++;
		end
		if (ltssm_state != target) begin
			errors++;
			$display("timeout: trainer never reached state %s", target.name());
		end
	endtask

	// one receiver detection round, partner found or not
	task automatic run_detect(input logic found);
		int n;
		n = 0;
		while (!partner_detect && n < 100) begin
			next_cycle();
			n++;
		end
		if (!partner_detect) begin
			errors++;
			$display("timeout: trainer never asked for receiver detection");
		end
		partner_detected = found;
		partner_looking  = 1'b1;
		repeat (3) next_cycle();
		partner_looking = 1'b0;	// result sampled on this fall
		next_cycle();
		partner_detected = 1'b0;
	endtask

	// one lfps burst on the receive pair, then watch the pulse outputs
	task automatic apply_burst(input string name, input int width, input int gap,
		input logic [3:0] expected);
		logic [3:0] seen;
		int         pulses;
		seen   = '0;
		pulses = 0;
		port_rx_elecidle = 1'b0;
		repeat (width) next_cycle();
		port_rx_elecidle = 1'b1;
		repeat (6) begin
			next_cycle();
			seen = seen | pulses_now;
			if (pulses_now != '0)
				pulses++;
		end
		check_value({name, " kind"}, expected, seen);
		check_value({name, " pulses"}, (expected != '0) ? 1 : 0, pulses);
		repeat (gap - 6) next_cycle();
	endtask

	// low periods of the transmit line and their start spacing
	task automatic measure_tx_bursts(input int count);
		int n;
		int low;
		int high;
		n = 0;
		while (port_tx_elecidle && n < 200) begin
			next_cycle();
			n++;
		end
		if (port_tx_elecidle) begin
			errors++;
			$display("timeout: no polling burst was transmitted");
		end
		for (int i = 0; i < count; i++) begin
			low = 0;
			while (!port_tx_elecidle && low < 100) begin
				next_cycle();
				low++;
			end
			high = 0;
			while (port_tx_elecidle && high < 100) begin
				next_cycle();
				high++;
			end
			check_value("tx_burst_width", 15, low);
			check_value("tx_burst_repeat", 60, low + high);
		end
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////
	initial begin
		int cyc;
		slow_clk              = 1'b0;
		lfps_send_reset_local = 1'b1;
		vbus_present          = 1'b1;
		port_rx_elecidle      = 1'b1;
		port_rx_valid         = 1'b0;	// lfps only, no data
		partner_looking       = 1'b0;
		partner_detected      = 1'b0;
		errors                = 0;
		checks                = 0;
		void'($urandom(32'h1f4f));

		rows[0] = '{"u1_exit", 23, 37, 60, 4'b0001};
		rows[1] = '{"u2lb_exit", 43, 77, 60, 4'b0100};
		rows[2] = '{"u3_wakeup", 83, 157, 60, 4'b1000};
		rows[3] = '{"no_kind", 8, 8, 60, 4'b0000};	// between ping and poll
		rows[4] = '{"poll_first", 12, 17, 85, 4'b0000};
		rows[5] = '{"poll_second", 12, 17, 60, 4'b0001};
		rows[6] = '{"ping_first", 3, 3, 397, 4'b0000};	// 400 cycle spacing
		rows[7] = '{"ping_second", 3, 3, 60, 4'b0000};
		rows[8] = '{"ping_pair", 3, 3, 60, 4'b0010};	// 63 cycles after ping_second

		next_cycle();
		apply_reset();

		// detection never finds a partner
		repeat (8) run_detect(1'b0);
		wait_state(lt_ss_disabled, 10, cyc);
		check_value("detect_fail_state", lt_ss_disabled, ltssm_state);

		// classifier table
		apply_reset();
		foreach (rows[i])
			apply_burst(rows[i].name, pick_width(rows[i].width_lo, rows[i].width_hi),
				rows[i].gap, rows[i].expected);

		// polling with poll bursts coming back
		apply_reset();
		run_detect(1'b1);
		wait_state(lt_polling_lfps, 10, cyc);
		measure_tx_bursts(3);
		apply_burst("poll_feed_1", pick_width(12, 17), 85, 4'b0000);
		apply_burst("poll_feed_2", pick_width(12, 17), 85, 4'b0001);
		apply_burst("poll_feed_3", pick_width(12, 17), 85, 4'b0001);
		wait_state(lt_polling_done, 4000, cyc);
		check_value("polling_done_state", lt_polling_done, ltssm_state);

		// polling with a silent partner
		apply_reset();
		run_detect(1'b1);
		wait_state(lt_polling_lfps, 10, cyc);
		wait_state(lt_ss_disabled, 4500, cyc);
		check_value("polling_timeout_state", lt_ss_disabled, ltssm_state);
		check_value("polling_timeout_late", 1, (cyc >= 3990) ? 1 : 0);

		errors += u_usb3_lfps_top.u_lfps_event_fifo.u_fifo_assertions.fail_count;
		errors += u_usb3_lfps_top.u_lfps_link_trainer.u_lfps_tx_burst.u_tx_assertions.fail_count;

		$display("errors: %0d of %0d checks", errors, checks);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
hw/lfps_pkg.sv
hw/lfps_event_if.sv
hw/lfps_tx_burst.sv
hw/lfps_rx_classifier.sv
hw/lfps_event_fifo.sv
hw/lfps_link_trainer.sv
hw/usb3_lfps_top.sv
testbench/lfps_assertions.sv
testbench/tb_usb3_lfps.sv
